/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module cache_hierarchy_tb -f verilog.f

./obj_dir/Vcache_hierarchy_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation reported failures."
    exit 1
fi
echo "Simulation finished without failures."

/* src/arbiter.sv */
module arbiter
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  line_req_t icache_req,
    input  line_req_t dcache_req,
    output line_rsp_t icache_rsp,
    output line_rsp_t dcache_rsp,
    output line_req_t mem_req,
    input  line_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        idle,
        icache,
        dcache
    } arb_state_t;

    arb_state_t state, next_state;

    logic i_pending;
    logic d_pending;

    assign i_pending = icache_req.read;
    assign d_pending = dcache_req.read || dcache_req.write;

    // A grant is only given up on a memory response, or when its client has gone quiet.
    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (i_pending)
                    next_state = icache;
                else if (d_pending)
                    next_state = dcache;
            end
            icache: begin
                if (mem_rsp.resp || !i_pending) begin
                    if (d_pending)
                        next_state = dcache;
                    else if (!i_pending)
                        next_state = idle;
                end
            end
            dcache: begin
                if (mem_rsp.resp || !d_pending) begin
                    if (i_pending)
                        next_state = icache;
                    else if (!d_pending)
                        next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_comb begin
        mem_req = '0; // Nothing reaches memory while idle.
        icache_rsp = '0;
        dcache_rsp = '0;
        case (state)
            icache: begin
                mem_req = icache_req;
                icache_rsp = mem_rsp;
            end
            dcache: begin
                mem_req = dcache_req;
                dcache_rsp = mem_rsp;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= idle;
        else
            state <= next_state;
    end

endmodule : arbiter

/* src/cache_hierarchy.sv */
module cache_hierarchy
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_req_t  inst_req,
    input  cpu_req_t  data_req,
    output cpu_rsp_t  inst_rsp,
    output cpu_rsp_t  data_rsp,
    output line_req_t mem_req,
    input  line_rsp_t mem_rsp
);

    line_req_t icache_line;
    line_req_t dcache_line;
    line_rsp_t icache_line_rsp;
    line_rsp_t dcache_line_rsp;

    icache icache_inst (
        .clk      (clk),
        .rst      (rst),
        .inst_req (inst_req),
        .inst_rsp (inst_rsp),
        .line_req (icache_line),
        .line_rsp (icache_line_rsp)
    );

    dcache dcache_inst (
        .clk      (clk),
        .rst      (rst),
        .data_req (data_req),
        .data_rsp (data_rsp),
        .line_req (dcache_line),
        .line_rsp (dcache_line_rsp)
    );

    // Both caches share the single main-memory port.
    arbiter arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_line),
        .dcache_req (dcache_line),
        .icache_rsp (icache_line_rsp),
        .dcache_rsp (dcache_line_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule : cache_hierarchy

/* src/dcache.sv */
module dcache
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_req_t  data_req,
    output cpu_rsp_t  data_rsp,
    output line_req_t line_req,
    input  line_rsp_t line_rsp
);

    typedef enum logic [1:0] {
        lookup,
        write_back,
        fill
    } dcache_state_t;

    dcache_state_t state, next_state;

    cache_addr_u req_addr;
    cache_addr_u victim_addr;
    logic [set_bits-1:0] set_idx;
    logic [offset_bits-3:0] word_idx;
    logic [tag_bits-1:0] tags [num_sets];
    logic [num_sets-1:0] valid;
    logic [num_sets-1:0] dirty;
    cache_line lines [num_sets];
    rv32i_word cur_word;
    rv32i_word merged_word;
    logic active;
    logic hit;
    logic write_hit;
    logic fill_done;

    assign req_addr.raw = data_req.addr;
    assign set_idx = req_addr.fields.set;
    assign word_idx = req_addr.fields.offset[offset_bits-1:2];
    assign active = data_req.read || data_req.write;
    assign hit = valid[set_idx] && (tags[set_idx] == req_addr.fields.tag);
    assign write_hit = (state == lookup) && data_req.write && hit;
    assign fill_done = (state == fill) && line_rsp.resp;
    assign cur_word = lines[set_idx][32*word_idx +: 32];

    // The victim sits in the same set, so only its tag comes from storage.
    always_comb begin
        victim_addr.fields.tag = tags[set_idx];
        victim_addr.fields.set = set_idx;
        victim_addr.fields.offset = '0;
    end

    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < 4; b++) begin
            if (data_req.wmask[b])
                merged_word[8*b +: 8] = data_req.wdata[8*b +: 8];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lookup: begin
                if (active && !hit)
                    next_state = (valid[set_idx] && dirty[set_idx]) ? write_back : fill;
            end
            write_back: if (line_rsp.resp) next_state = fill;
            fill:       if (line_rsp.resp) next_state = lookup;
            default:    next_state = lookup;
        endcase
    end

    always_comb begin
        data_rsp.resp = (state == lookup) && active && hit;
        data_rsp.rdata = cur_word; // Old word on a write, unused by the CPU.
        line_req.read = (state == fill);
        line_req.write = (state == write_back);
        line_req.addr = (state == write_back) ? victim_addr.raw
                        : {req_addr.raw[31:offset_bits], {offset_bits{1'b0}}};
        line_req.wdata = lines[set_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lookup;
            valid <= '0;
            dirty <= '0;
        end else begin
            state <= next_state;
            if (fill_done) begin
                valid[set_idx] <= 1'b1;
                dirty[set_idx] <= 1'b0;
            end else if (write_hit) begin
                dirty[set_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[set_idx] <= req_addr.fields.tag;
            lines[set_idx] <= line_rsp.rdata;
        end else if (write_hit) begin
            lines[set_idx][32*word_idx +: 32] <= merged_word;
        end
    end

endmodule : dcache

/* src/icache.sv */
module icache
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  cpu_req_t  inst_req,
    output cpu_rsp_t  inst_rsp,
    output line_req_t line_req,
    input  line_rsp_t line_rsp
);

    typedef enum logic {
        lookup,
        fill
    } icache_state_t;

    icache_state_t state, next_state;

    cache_addr_u req_addr;
    logic [set_bits-1:0] set_idx;
    logic [offset_bits-3:0] word_idx;
    logic [tag_bits-1:0] tags [num_sets];
    logic [num_sets-1:0] valid;
    cache_line lines [num_sets];
    logic hit;
    logic fill_done;

    assign req_addr.raw = inst_req.addr;
    assign set_idx = req_addr.fields.set;
    assign word_idx = req_addr.fields.offset[offset_bits-1:2]; // Byte bits are ignored.
    assign hit = valid[set_idx] && (tags[set_idx] == req_addr.fields.tag);
    assign fill_done = (state == fill) && line_rsp.resp;

    always_comb begin
        next_state = state;
        case (state)
            lookup: if (inst_req.read && !hit) next_state = fill;
            fill:   if (line_rsp.resp) next_state = lookup;
            default: next_state = lookup;
        endcase
    end

    // After a fill the request is answered by an ordinary hit in lookup.
    always_comb begin
        inst_rsp.resp = (state == lookup) && inst_req.read && hit;
        inst_rsp.rdata = lines[set_idx][32*word_idx +: 32];
        line_req.read = (state == fill);
        line_req.write = 1'b0;
        line_req.addr = {req_addr.raw[31:offset_bits], {offset_bits{1'b0}}};
        line_req.wdata = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lookup;
            valid <= '0;
        end else begin
            state <= next_state;
            if (fill_done)
                valid[set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[set_idx] <= req_addr.fields.tag;
            lines[set_idx] <= line_rsp.rdata;
        end
    end

endmodule : icache

/* src/rv32i_types.sv */
package rv32i_types;

    localparam int num_sets = 8;
    localparam int offset_bits = 5;
    localparam int set_bits = 3;
    localparam int tag_bits = 24;

    typedef logic [31:0] rv32i_word;
    typedef logic [255:0] cache_line; // Eight words per line.

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } cache_addr_fields_t;

    // The same address word, seen whole or split for the cache lookup.
    typedef union packed {
        rv32i_word          raw;
        cache_addr_fields_t fields;
    } cache_addr_u;

    typedef struct packed {
        logic      read;
        logic      write;
        rv32i_word addr;
        rv32i_word wdata;
        logic [3:0] wmask; // One bit per byte lane.
    } cpu_req_t;

    typedef struct packed {
        logic      resp;
        rv32i_word rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic      read;
        logic      write;
        rv32i_word addr;
        cache_line wdata;
    } line_req_t;

    typedef struct packed {
        logic      resp;
        cache_line rdata;
    } line_rsp_t;

endpackage : rv32i_types

/* verif/arbiter_checker.sv */
module arbiter_checker
    import rv32i_types::*;
(
    input logic      clk,
    input logic      rst,
    input line_req_t icache_req,
    input line_req_t dcache_req,
    input line_rsp_t icache_rsp,
    input line_rsp_t dcache_rsp,
    input line_req_t mem_req,
    input line_rsp_t mem_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;

    one_operation: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
    else begin
        $error("Read and write are both high on the memory port.");
        failures++;
    end

    // A memory response goes back to exactly one cache.
    one_response: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.resp |-> (icache_rsp.resp != dcache_rsp.resp))
    else begin
        $error("A memory response did not reach exactly one cache.");
        failures++;
    end

    // A waiting request keeps its address and data until memory answers.
    stable_request: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && !mem_rsp.resp
        |=> $stable(mem_req.addr) && $stable(mem_req.wdata))
    else begin
        $error("The memory request changed before its response.");
        failures++;
    end

    icache_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
        icache_rsp.resp |-> icache_req.read)
    else begin
        $error("Instruction cache line response without a line request.");
        failures++;
    end

    dcache_rsp_has_req: assert property (@(posedge clk) disable iff (rst)
        dcache_rsp.resp |-> (dcache_req.read || dcache_req.write))
    else begin
        $error("Data cache line response without a line request.");
        failures++;
    end

endmodule : arbiter_checker

/* verif/cache_hierarchy_tb.sv */
module cache_hierarchy_tb
    import rv32i_types::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_reqs = 300;
    localparam int req_limit = 40;
    localparam int timeout_cycles = 600 * req_limit;

    logic      clk = 1'b0;
    logic      rst;
    cpu_req_t  inst_req;
    cpu_req_t  data_req;
    cpu_rsp_t  inst_rsp;
    cpu_rsp_t  data_rsp;
    line_req_t mem_req;
    line_rsp_t mem_rsp;

    rv32i_word lfsr = 32'd40;
    rv32i_word ref_words [1024]; // Word view of the whole 4 KB space.
    cache_line mem_lines [128];
    int inst_errors = 0;
    int data_errors = 0;
    int line_errors = 0;
    int protocol_errors = 0;
    int cycles = 0;

    cache_hierarchy cache_hierarchy_inst (.*);

    bind arbiter arbiter_checker arbiter_checker_inst (.*);

    always #10 clk = ~clk;

    // Galois LFSR that is stepped once for every bit handed out.
    function automatic rv32i_word take_bits(input int n);
        rv32i_word v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic cache_line ref_line(input logic [6:0] idx);
        cache_line line;
        line = '0;
        for (int w = 0; w < 8; w++)
            line = {ref_words[{idx, w[2:0]}], line[255:32]}; // Word 0 ends up lowest.
        return line;
    endfunction

    function automatic rv32i_word merge_bytes(input rv32i_word old, input rv32i_word wdata,
                                              input logic [3:0] mask);
        rv32i_word lanes;
        lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~lanes) | (wdata & lanes);
    endfunction

    function automatic int assertion_failures();
        return int'(cache_hierarchy_inst.arbiter_inst.arbiter_checker_inst.failures);
    endfunction

    task automatic check_inst(input cpu_rsp_t rsp, input rv32i_word addr);
        rv32i_word exp;
        exp = ref_words[addr[11:2]];
        if (rsp.rdata !== exp) begin
            inst_errors++;
            $display("MISMATCH at %0t ns: fetch %h expected %h got %h",
                     $time, addr, exp, rsp.rdata);
        end
    endtask

    task automatic check_data(input cpu_rsp_t rsp, input rv32i_word addr);
        rv32i_word exp;
        exp = ref_words[addr[11:2]];
        if (rsp.rdata !== exp) begin
            data_errors++;
            $display("MISMATCH at %0t ns: load %h expected %h got %h",
                     $time, addr, exp, rsp.rdata);
        end
    endtask

    task automatic check_line(input cache_line got, input logic [6:0] idx);
        cache_line exp;
        exp = ref_line(idx);
        if (got !== exp) begin
            line_errors++;
            $display("MISMATCH at %0t ns: memory line %h expected %h got %h",
                     $time, {20'h0, idx, 5'h0}, exp, got);
        end
    endtask

    task automatic report_counts();
        $display("Error counts: fetch %0d, load %0d, memory %0d, protocol %0d, assertion %0d",
                 inst_errors, data_errors, line_errors, protocol_errors, assertion_failures());
    endtask

    task automatic stop_on_hang(input string what);
        $display("Timeout at %0t ns: %s, the run hung.", $time, what);
        report_counts();
        $display("Errors found");
        $finish;
    endtask

    task automatic wait_resp(input bit data_side);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > req_limit)
                stop_on_hang(data_side ? "a data request got no response"
                                       : "an instruction request got no response");
        end while (!(data_side ? data_rsp.resp : inst_rsp.resp));
    endtask

    task automatic run_inst_stream();
        rv32i_word r;
        rv32i_word addr;
        for (int n = 0; n < num_reqs; n++) begin
            @(posedge clk);
            #2;
            r = take_bits(9);
            addr = {21'h0, r[8:0], 2'b00}; // Fetches stay in the lower 2 KB.
            inst_req.read = 1'b1;
            inst_req.addr = addr;
            wait_resp(1'b0);
            check_inst(inst_rsp, addr);
        end
        @(posedge clk);
        #2;
        inst_req = '0;
    endtask

    task automatic run_data_stream();
        rv32i_word r;
        rv32i_word addr;
        rv32i_word wdata;
        logic [3:0] wmask;
        int sweep;
        for (int n = 0; n < num_reqs + num_sets; n++) begin
            @(posedge clk);
            #2;
            r = take_bits(9);
            sweep = n - num_reqs;
            // Eight tags over four sets keep evictions frequent. The closing sweep
            // reads one lower-half line per set, so every dirty line goes to memory.
            addr = (n < num_reqs) ? {20'h0, 1'b1, r[7:5], 1'b0, r[4:3], r[2:0], 2'b00}
                                  : {24'h0, sweep[2:0], 5'h0};
            wdata = '0;
            wmask = '0;
            data_req.write = (n < num_reqs) && r[8];
            data_req.read = !data_req.write;
            if (data_req.write) begin
                wdata = take_bits(32);
                r = take_bits(4);
                wmask = r[3:0];
            end
            data_req.addr = addr;
            data_req.wdata = wdata;
            data_req.wmask = wmask;
            wait_resp(1'b1);
            if (data_req.write)
                ref_words[addr[11:2]] = merge_bytes(ref_words[addr[11:2]], wdata, wmask);
            else
                check_data(data_rsp, addr);
        end
        @(posedge clk);
        #2;
        data_req = '0;
    endtask

    // Main memory behind the arbiter answers each line access after 1 to 4 cycles.
    initial begin : memory_model
        line_req_t req;
        rv32i_word r;
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (!rst && (mem_req.read || mem_req.write)) begin
                req = mem_req;
                r = take_bits(2);
                if (req.addr[31:12] != '0 || req.addr[4:0] != '0) begin
                    protocol_errors++;
                    $display("Memory access at %0t ns to a bad line address %h.",
                             $time, req.addr);
                end
                repeat (r[1:0]) @(posedge clk);
                @(posedge clk);
                #2;
                if (req.write)
                    mem_lines[req.addr[11:5]] = req.wdata;
                mem_rsp.resp = 1'b1;
                mem_rsp.rdata = mem_lines[req.addr[11:5]];
                @(posedge clk);
                #2;
                mem_rsp = '0;
            end
        end
    end

    // Nothing may reach memory without a CPU request behind it.
    always @(negedge clk) begin
        if (!rst) begin
            if ((mem_req.read || mem_req.write) && !inst_req.read
                    && !data_req.read && !data_req.write) begin
                protocol_errors++;
                $display("Memory request at %0t ns while no CPU request is pending.", $time);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles)
            stop_on_hang("the cycle limit was reached");
    end

    initial begin : main
        rst = 1'b1;
        inst_req = '0;
        data_req = '0;
        for (int i = 0; i < 1024; i++)
            ref_words[i[9:0]] = take_bits(32);
        for (int l = 0; l < 128; l++)
            mem_lines[l[6:0]] = ref_line(l[6:0]);
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        repeat (3) @(posedge clk); // Quiet cycles after reset.
        fork
            run_inst_stream();
            run_data_stream();
        join
        for (int l = 0; l < 128; l++)
            check_line(mem_lines[l[6:0]], l[6:0]);
        report_counts();
        if (inst_errors + data_errors + line_errors + protocol_errors
                + assertion_failures() == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule : cache_hierarchy_tb

/* verilog.f */
src/rv32i_types.sv
src/icache.sv
src/dcache.sv
src/arbiter.sv
src/cache_hierarchy.sv
verif/arbiter_checker.sv
verif/cache_hierarchy_tb.sv
